//--- rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes of the control transfers the predictor looks at
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // addi x0, x0, 0
    localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

    // Conditional branch layout
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    // Jump and link layout
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // Same word, read through the view the opcode selects
    typedef union packed {
        b_type_t b;
        j_type_t j;
    } ctrl_xfer_u;

endpackage

//--- frontend_pkg.sv
package frontend_pkg;

    // Reset fetch address
    localparam logic [31:0] START_ADDRESS = 32'h0000_0000;

    // Instruction ROM geometry and image
    localparam int    ROM_WORDS      = 64;
    localparam int    ROM_ADDR_WIDTH = $clog2(ROM_WORDS);
    localparam string ROM_FILE       = "program.hex";

    // Epoch tag, steps on every redirect
    localparam int TAG_WIDTH = 3;

    typedef logic [TAG_WIDTH-1:0] tag_t;

endpackage

//--- fetch_out_if.sv
`timescale 1ns/100ps

interface fetch_out_if
    import frontend_pkg::*;
();

    logic [31:0] instruction;
    logic [31:0] pc;
    tag_t        tag;
    // Low while fetch is redirecting
    logic        valid;

    modport source (
        output instruction,
        output pc,
        output tag,
        output valid
    );

    modport sink (
        input instruction,
        input pc,
        input tag,
        input valid
    );

endinterface

//--- instr_rom.sv
`timescale 1ns/100ps

module instr_rom
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic [31:0] addr_i,
    output logic [31:0] data_o
);

    logic [31:0]               mem [ROM_WORDS];
    logic [ROM_ADDR_WIDTH-1:0] word_index;

    ////////////////////////////////////////////////////////////
    // Program image
    ////////////////////////////////////////////////////////////

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // Byte address to word index, upper bits alias
    assign word_index = addr_i[ROM_ADDR_WIDTH+1:2];

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // One cycle latency, no enable
    always_ff @(posedge clk) begin
        data_o <= mem[word_index];
    end

endmodule

//--- fetch.sv
`timescale 1ns/100ps

module fetch
    import rv_isa_pkg::*;
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        enable_i,
    input  logic        jump_i,
    input  logic [31:0] jump_target_i,
    input  logic        bp_take_i,
    input  logic [31:0] bp_target_i,
    input  logic        jump_rollback_i,
    input  logic [31:0] mtvec_i,
    input  logic [31:0] mepc_i,
    input  logic        exception_raised_i,
    input  logic        machine_return_i,
    input  logic        interrupt_ack_i,
    output logic [31:0] instruction_address_o,
    input  logic [31:0] instruction_data_i,
    output logic        rollback_o,
    fetch_out_if.source out
);

    logic        trap;
    logic        predict;
    logic        taken;
    logic        redirect;
    logic [31:0] iaddr_advance;
    logic [31:0] iaddr_next;
    logic [31:0] iaddr_rollback;
    logic [31:0] iaddr_jumped;
    logic [31:0] iaddr_jumped_r;
    logic        jumped_r;
    logic        jumped_r2;
    logic        jumping;
    logic        enable_r;
    logic [31:0] idata_held;
    logic [31:0] instruction_fetched;
    logic [31:0] pc_update;
    tag_t        tag;
    tag_t        tag_next;
    tag_t        tag_r;
    logic        rollback_pend;
    logic        rollback_r;

    ////////////////////////////////////////////////////////////
    // Instruction address loop
    ////////////////////////////////////////////////////////////

    assign trap    = exception_raised_i || interrupt_ack_i;
    // Prediction only counts on an accepted instruction
    assign predict = enable_i && bp_take_i;
    assign taken   = machine_return_i || trap || jump_i || predict;
    assign redirect = taken || jump_rollback_i;

    assign iaddr_advance = instruction_address_o + 32'd4;

    always_comb begin
        if (machine_return_i)
            iaddr_next = mepc_i;
        else if (trap)
            iaddr_next = mtvec_i;
        else if (jump_i)
            iaddr_next = jump_target_i;
        else if (predict)
            iaddr_next = bp_target_i;
        else if (jump_rollback_i)
            iaddr_next = iaddr_rollback;
        else if (enable_i)
            iaddr_next = iaddr_advance;
        else
            iaddr_next = instruction_address_o;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            instruction_address_o <= START_ADDRESS;
        else
            instruction_address_o <= {iaddr_next[31:2], 2'b00};
    end

    // Not-taken path of the branch being predicted
    always_ff @(posedge clk) begin
        if (predict)
            iaddr_rollback <= out.pc + 32'd4;
    end

    ////////////////////////////////////////////////////////////
    // Redirect bubbles
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r  <= 1'b1;
            jumped_r2 <= 1'b1;
            jumping   <= 1'b1;
        end else begin
            if (redirect)
                jumped_r <= 1'b1;
            else if (enable_i)
                jumped_r <= 1'b0;
            if (enable_i)
                jumped_r2 <= jumped_r;
            // Stays high until the target word reaches the output
            if (redirect || jumped_r)
                jumping <= 1'b1;
            else if (enable_i)
                jumping <= 1'b0;
        end
    end

    // Target address follows the ROM data by one stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iaddr_jumped   <= START_ADDRESS;
            iaddr_jumped_r <= START_ADDRESS;
        end else begin
            if (redirect)
                iaddr_jumped <= iaddr_next;
            if (jumped_r)
                iaddr_jumped_r <= iaddr_jumped;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r   <= 1'b0;
            idata_held <= INSTR_NOP;
        end else begin
            enable_r <= enable_i;
            // Catch the word arriving in the first stalled cycle
            if (!enable_i && enable_r)
                idata_held <= instruction_data_i;
        end
    end

    assign instruction_fetched = enable_r ? instruction_data_i : idata_held;
    assign pc_update = jumped_r2 ? iaddr_jumped_r : out.pc + 32'd4;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out.instruction <= INSTR_NOP;
            out.pc          <= START_ADDRESS;
        end else if (enable_i) begin
            out.instruction <= instruction_fetched;
            out.pc          <= pc_update;
        end
    end

    assign out.valid = !jumping;

    ////////////////////////////////////////////////////////////
    // Epoch tag
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (taken && !jump_rollback_i)
            tag_next = tag + 1'b1;
        else if (jump_rollback_i && !taken)
            tag_next = tag - 1'b1;
        else
            tag_next = tag;
    end

    // Two enabled stages line the tag up with its instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag     <= '0;
            tag_r   <= '1;
            out.tag <= '1;
        end else begin
            tag <= tag_next;
            if (enable_i) begin
                tag_r   <= tag;
                out.tag <= tag_r;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Rollback report
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_pend <= 1'b0;
            rollback_r    <= 1'b0;
            rollback_o    <= 1'b0;
        end else begin
            // Request seen during a stall waits for the next enable
            if (jump_rollback_i && !enable_i)
                rollback_pend <= 1'b1;
            else if (enable_i)
                rollback_pend <= 1'b0;
            if (enable_i) begin
                rollback_r <= jump_rollback_i || rollback_pend;
                rollback_o <= rollback_r;
            end
        end
    end

endmodule

//--- static_predictor.sv
`timescale 1ns/100ps

module static_predictor
    import rv_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    fetch_out_if.sink   fetched,
    output logic        bp_take_o,
    output logic [31:0] bp_target_o
);

    ctrl_xfer_u  xfer;
    logic        is_jal;
    logic        is_back_branch;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        predicted_r;
    logic [31:0] predicted_pc_r;
    logic        redirecting;

    assign xfer = fetched.instruction;

    assign is_jal = (xfer.j.opcode == OPC_JAL);
    // Negative offset means a loop, assume it is taken
    assign is_back_branch = (xfer.b.opcode == OPC_BRANCH) && xfer.b.imm_12;

    assign imm_b = {{20{xfer.b.imm_12}}, xfer.b.imm_11, xfer.b.imm_10_5,
                    xfer.b.imm_4_1, 1'b0};
    assign imm_j = {{12{xfer.j.imm_20}}, xfer.j.imm_19_12, xfer.j.imm_11,
                    xfer.j.imm_10_1, 1'b0};

    assign bp_target_o = fetched.pc + (is_jal ? imm_j : imm_b);

    // Output moved on after a prediction, fetch is busy redirecting
    assign redirecting = predicted_r && (fetched.pc != predicted_pc_r);

    assign bp_take_o = fetched.valid && (is_jal || is_back_branch) && !redirecting;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            predicted_r <= 1'b0;
        else
            predicted_r <= bp_take_o;
    end

    always_ff @(posedge clk) begin
        predicted_pc_r <= fetched.pc;
    end

endmodule

//--- frontend_top.sv
`timescale 1ns/100ps

module frontend_top
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        ready_i,
    output logic        valid_o,
    output logic [31:0] instr_o,
    output logic [31:0] pc_o,
    output tag_t        tag_o,
    input  logic        jump_i,
    input  logic [31:0] jump_target_i,
    input  logic        jump_rollback_i,
    output logic        rollback_o,
    input  logic [31:0] mtvec_i,
    input  logic [31:0] mepc_i,
    input  logic        exception_raised_i,
    input  logic        machine_return_i,
    input  logic        interrupt_ack_i
);

    logic [31:0] rom_addr;
    logic [31:0] rom_data;
    logic        bp_take;
    logic [31:0] bp_target;

    fetch_out_if fetched_if ();

    instr_rom instr_rom_inst (
        .clk    (clk),
        .addr_i (rom_addr),
        .data_o (rom_data)
    );

    fetch fetch_inst (
        .clk                   (clk),
        .reset_n               (reset_n),
        .enable_i              (ready_i),
        .jump_i                (jump_i),
        .jump_target_i         (jump_target_i),
        .bp_take_i             (bp_take),
        .bp_target_i           (bp_target),
        .jump_rollback_i       (jump_rollback_i),
        .mtvec_i               (mtvec_i),
        .mepc_i                (mepc_i),
        .exception_raised_i    (exception_raised_i),
        .machine_return_i      (machine_return_i),
        .interrupt_ack_i       (interrupt_ack_i),
        .instruction_address_o (rom_addr),
        .instruction_data_i    (rom_data),
        .rollback_o            (rollback_o),
        .out                   (fetched_if.source)
    );

    static_predictor static_predictor_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetched     (fetched_if.sink),
        .bp_take_o   (bp_take),
        .bp_target_o (bp_target)
    );

    // Handshake and payload out to the pipeline
    assign valid_o = fetched_if.valid;
    assign instr_o = fetched_if.instruction;
    assign pc_o    = fetched_if.pc;
    assign tag_o   = fetched_if.tag;

endmodule

//--- frontend_assert.sv
`timescale 1ns/100ps

module frontend_assert
    import frontend_pkg::*;
(
    input logic        clk,
    input logic        reset_n,
    input logic        ready_i,
    input logic        valid_o,
    input logic [31:0] instr_o,
    input logic [31:0] pc_o,
    input tag_t        tag_o
);

    int violations = 0;

    // Output starts in a bubble
    reset_bubble: assert property (@(posedge clk) $rose(reset_n) |-> !valid_o)
        else begin
            $error("valid_o high in the cycle after reset release");
            violations++;
        end

    // A stalled valid word holds until it is taken
    stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (valid_o && !ready_i) |=> ($stable(instr_o) && $stable(pc_o) && $stable(tag_o)))
        else begin
            $error("outputs moved while valid_o was high and ready_i low");
            violations++;
        end

    tag_step: assert property (@(posedge clk) disable iff (!reset_n)
        $changed(tag_o) |-> $past(!valid_o || ready_i))
        else begin
            $error("tag_o changed on a stalled valid word");
            violations++;
        end

endmodule

bind frontend_top frontend_assert frontend_assert_inst (.*);

//--- tb_frontend.sv
`timescale 1ns/100ps

module tb_frontend
    import rv_isa_pkg::*;
    import frontend_pkg::*;
();

    logic        clk;
    logic        reset_n;
    logic        ready_i;
    logic        valid_o;
    logic [31:0] instr_o;
    logic [31:0] pc_o;
    tag_t        tag_o;
    logic        jump_i;
    logic [31:0] jump_target_i;
    logic        jump_rollback_i;
    logic        rollback_o;
    logic [31:0] mtvec_i;
    logic [31:0] mepc_i;
    logic        exception_raised_i;
    logic        machine_return_i;
    logic        interrupt_ack_i;

    logic [31:0] rom_image [ROM_WORDS];
    logic [31:0] rng_state;
    logic [31:0] exp_pc;
    tag_t        exp_tag;
    logic [31:0] got_pc;
    logic [31:0] got_instr;
    tag_t        got_tag;

    frontend_top frontend_top_inst (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
        abort_run();
    endtask

    task automatic hang_error(input string what);
        $display("error at %0t: %s", $time, what);
        abort_run();
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model of the predicted PC stream
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // JAL always, conditional branch only with a negative offset
    function automatic logic predicts_taken(input logic [31:0] word);
        ctrl_xfer_u w;
        w = word;
        return (w.j.opcode == OPC_JAL) || ((w.b.opcode == OPC_BRANCH) && w.b.imm_12);
    endfunction

    function automatic logic [31:0] model_next_pc(input logic [31:0] pc,
                                                  input logic [31:0] word);
        ctrl_xfer_u w;
        w = word;
        if (w.j.opcode == OPC_JAL)
            return pc + {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
        if ((w.b.opcode == OPC_BRANCH) && w.b.imm_12)
            return pc + {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
        return pc + 32'd4;
    endfunction

    ////////////////////////////////////////////////////////////
    // Driving and sampling
    ////////////////////////////////////////////////////////////

    task automatic apply_reset();
        reset_n            = 1'b0;
        ready_i            = 1'b1;
        jump_i             = 1'b0;
        jump_target_i      = 32'h0;
        jump_rollback_i    = 1'b0;
        mtvec_i            = 32'h0;
        mepc_i             = 32'h0;
        exception_raised_i = 1'b0;
        machine_return_i   = 1'b0;
        interrupt_ack_i    = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        exp_pc  = START_ADDRESS;
        exp_tag = '0;
    endtask

    // Sample mid-cycle, the transfer itself happens on the next rising edge
    task automatic accept_next(input logic random_ready);
        logic done;
        int   cycles;
        done   = 1'b0;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            if (valid_o && ready_i) begin
                got_pc    = pc_o;
                got_instr = instr_o;
                got_tag   = tag_o;
                done      = 1'b1;
            end
            @(posedge clk);
            #1;
            if (random_ready) begin
                rng_state = xorshift(rng_state);
                ready_i   = rng_state[0] | rng_state[1];
            end
            cycles++;
            if (!done && cycles > 50)
                hang_error("no instruction transfer within 50 cycles");
        end
    endtask

    task automatic check_transfer();
        logic [31:0] exp_instr;
        exp_instr = rom_image[exp_pc[ROM_ADDR_WIDTH+1:2]];
        assert (got_pc == exp_pc) else value_error("pc_o", got_pc, exp_pc);
        assert (got_instr == exp_instr) else value_error("instr_o", got_instr, exp_instr);
        assert (got_tag == exp_tag) else value_error("tag_o", got_tag, exp_tag);
        if (predicts_taken(exp_instr))
            exp_tag = exp_tag + 1'b1;
        exp_pc = model_next_pc(exp_pc, exp_instr);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_sequential();
        apply_reset();
        assert (!valid_o) else value_error("valid_o", valid_o, 1'b0);
        assert (!rollback_o) else value_error("rollback_o", rollback_o, 1'b0);
        assert (instr_o == INSTR_NOP) else value_error("instr_o", instr_o, INSTR_NOP);
        assert (tag_o == '1) else value_error("tag_o", tag_o, 3'b111);
        repeat (5) begin
            accept_next(1'b0);
            check_transfer();
        end
    endtask

    task automatic test_prediction();
        apply_reset();
        repeat (14) begin
            accept_next(1'b0);
            check_transfer();
        end
    endtask

    task automatic test_back_pressure();
        apply_reset();
        repeat (24) begin
            accept_next(1'b1);
            check_transfer();
        end
        ready_i = 1'b1;
    endtask

    // kind 0 is an execute jump, 1 an exception, 2 a trap return
    task automatic redirect_and_check(input int kind, input logic [31:0] target);
        ready_i = 1'b0;
        case (kind)
            0: begin
                jump_i        = 1'b1;
                jump_target_i = target;
            end
            1: begin
                exception_raised_i = 1'b1;
                mtvec_i            = target;
            end
            default: begin
                machine_return_i = 1'b1;
                mepc_i           = target;
            end
        endcase
        @(posedge clk);
        #1;
        jump_i             = 1'b0;
        exception_raised_i = 1'b0;
        machine_return_i   = 1'b0;
        ready_i            = 1'b1;
        exp_pc  = target;
        exp_tag = exp_tag + 1'b1;
        accept_next(1'b0);
        check_transfer();
    endtask

    task automatic test_redirects();
        apply_reset();
        repeat (2) begin
            accept_next(1'b0);
            check_transfer();
        end
        redirect_and_check(0, 32'h0000_000c);
        redirect_and_check(1, 32'h0000_0000);
        redirect_and_check(2, 32'h0000_0018);
        accept_next(1'b0);
        check_transfer();
    endtask

    task automatic test_rollback();
        logic [31:0] branch_pc;
        tag_t        branch_tag;
        int          cycles;
        apply_reset();
        // Up to the backward branch at 0x20
        repeat (7) begin
            accept_next(1'b0);
            check_transfer();
        end
        // Branch PC and epoch as the model sees them
        branch_pc  = exp_pc;
        branch_tag = exp_tag;
        accept_next(1'b0);
        check_transfer();
        jump_rollback_i = 1'b1;
        @(posedge clk);
        #1;
        jump_rollback_i = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!rollback_o) begin
            cycles++;
            if (cycles > 10)
                hang_error("rollback_o did not rise within 10 cycles");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        exp_pc  = branch_pc + 32'd4;
        exp_tag = branch_tag;
        accept_next(1'b0);
        check_transfer();
    endtask

    initial begin
        clk       = 1'b0;
        rng_state = 32'd43321;
        $readmemh(ROM_FILE, rom_image);
        test_sequential();
        test_prediction();
        test_back_pressure();
        test_redirects();
        test_rollback();
        if (frontend_top_inst.frontend_assert_inst.violations != 0) begin
            hang_error("bound handshake assertions reported violations");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- program.hex
// One 32-bit instruction word per line in hex, starting at byte address 0
// Trailing comments give the byte address and the assembly
00100093 // 00 addi x1, x0, 1
00200113 // 04 addi x2, x0, 2
00000463 // 08 beq  x0, x0, +8   forward, predicted not taken
00300193 // 0c addi x3, x0, 3
0080006f // 10 jal  x0, +8       predicted taken
00500293 // 14 addi x5, x0, 5    skipped by the jal
00108093 // 18 addi x1, x1, 1    loop head
fff10113 // 1c addi x2, x2, -1
fe011ce3 // 20 bne  x2, x0, -8   backward, predicted taken
00600313 // 24 addi x6, x0, 6    loop exit
fd9ff06f // 28 jal  x0, -40      back to start
00000013 // 2c nop
00000013 // 30 nop
00000013 // 34 nop

//--- build.f
rv_isa_pkg.sv
frontend_pkg.sv
fetch_out_if.sv
instr_rom.sv
fetch.sv
static_predictor.sv
frontend_top.sv
frontend_assert.sv
tb_frontend.sv

//--- Bender.yml
package:
  name: rv_frontend

sources:
  - rv_isa_pkg.sv
  - frontend_pkg.sv
  - fetch_out_if.sv
  - instr_rom.sv
  - fetch.sv
  - static_predictor.sv
  - frontend_top.sv
  - target: simulation
    files:
      - frontend_assert.sv
      - tb_frontend.sv
